// File: hw/rv_exec_pkg.sv
package rv_exec_pkg;

    localparam int XLEN = 32;

    // Major opcodes, bits [6:0] of the word.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA.

    typedef enum logic [4:0] {
        ALU_NOP   = 5'd0,
        ALU_ADD   = 5'd1,
        ALU_SUB   = 5'd2,
        ALU_SLL   = 5'd3,
        ALU_SLT   = 5'd4,
        ALU_SLTU  = 5'd5,
        ALU_XOR   = 5'd6,
        ALU_SRL   = 5'd7,
        ALU_SRA   = 5'd8,
        ALU_OR    = 5'd9,
        ALU_AND   = 5'd10,
        ALU_LUI   = 5'd11,
        ALU_AUIPC = 5'd12,
        ALU_JAL   = 5'd13,
        ALU_JALR  = 5'd14,
        ALU_BEQ   = 5'd15,
        ALU_BNE   = 5'd16,
        ALU_BLT   = 5'd17,
        ALU_BGE   = 5'd18,
        ALU_BLTU  = 5'd19,
        ALU_BGEU  = 5'd20
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset bits are scattered over the word.
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } rv_instr_u;

endpackage

// File: hw/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    output logic                              in_ready,
    input  logic [31:0]                       instr,
    input  logic [rv_exec_pkg::XLEN-1:0]      rs1_data,
    input  logic [rv_exec_pkg::XLEN-1:0]      rs2_data,
    input  logic [rv_exec_pkg::XLEN-1:0]      pc,
    output logic                              dec_valid,
    input  logic                              dec_ready,
    output rv_exec_pkg::alu_op_e              dec_op,
    output logic [rv_exec_pkg::XLEN-1:0]      dec_a,
    output logic [rv_exec_pkg::XLEN-1:0]      dec_b,
    output logic [rv_exec_pkg::XLEN-1:0]      dec_pc,
    output logic [rv_exec_pkg::XLEN-1:0]      dec_imm,
    output logic                              dec_illegal
);

    rv_exec_pkg::rv_instr_u               iw;
    rv_exec_pkg::alu_op_e                 op_d;
    logic [rv_exec_pkg::XLEN-1:0]         b_d;
    logic [rv_exec_pkg::XLEN-1:0]         imm_d;
    logic                                 illegal_d;
    logic [rv_exec_pkg::XLEN-1:0]         i_imm;
    logic [rv_exec_pkg::XLEN-1:0]         b_imm;
    logic [rv_exec_pkg::XLEN-1:0]         u_imm;
    logic [rv_exec_pkg::XLEN-1:0]         j_imm;

    assign iw = instr;

    // Sign-extended immediates.
    assign i_imm = {{20{iw.i_fmt.imm_11_0[11]}}, iw.i_fmt.imm_11_0};
    assign b_imm = {{19{iw.b_fmt.imm_12}}, iw.b_fmt.imm_12, iw.b_fmt.imm_11,
                    iw.b_fmt.imm_10_5, iw.b_fmt.imm_4_1, 1'b0};
    assign u_imm = {iw.u_fmt.imm_31_12, 12'b0};
    assign j_imm = {{11{iw.j_fmt.imm_20}}, iw.j_fmt.imm_20, iw.j_fmt.imm_19_12,
                    iw.j_fmt.imm_11, iw.j_fmt.imm_10_1, 1'b0};

    always_comb
    begin
        op_d      = rv_exec_pkg::ALU_NOP;
        b_d       = rs2_data;
        imm_d     = '0;
        illegal_d = 1'b0;
        case (iw.r_fmt.opcode)
            rv_exec_pkg::OPC_OP:
            begin
                case ({iw.r_fmt.funct7, iw.r_fmt.funct3})
                    {rv_exec_pkg::F7_BASE, 3'b000}: op_d = rv_exec_pkg::ALU_ADD;
                    {rv_exec_pkg::F7_ALT,  3'b000}: op_d = rv_exec_pkg::ALU_SUB;
                    {rv_exec_pkg::F7_BASE, 3'b001}: op_d = rv_exec_pkg::ALU_SLL;
                    {rv_exec_pkg::F7_BASE, 3'b010}: op_d = rv_exec_pkg::ALU_SLT;
                    {rv_exec_pkg::F7_BASE, 3'b011}: op_d = rv_exec_pkg::ALU_SLTU;
                    {rv_exec_pkg::F7_BASE, 3'b100}: op_d = rv_exec_pkg::ALU_XOR;
                    {rv_exec_pkg::F7_BASE, 3'b101}: op_d = rv_exec_pkg::ALU_SRL;
                    {rv_exec_pkg::F7_ALT,  3'b101}: op_d = rv_exec_pkg::ALU_SRA;
                    {rv_exec_pkg::F7_BASE, 3'b110}: op_d = rv_exec_pkg::ALU_OR;
                    {rv_exec_pkg::F7_BASE, 3'b111}: op_d = rv_exec_pkg::ALU_AND;
                    default:                        illegal_d = 1'b1;
                endcase
            end
            rv_exec_pkg::OPC_OP_IMM:
            begin
                b_d   = i_imm;  // Shamt sits in the low five bits.
                imm_d = i_imm;
                case (iw.i_fmt.funct3)
                    3'b000: op_d = rv_exec_pkg::ALU_ADD;
                    3'b010: op_d = rv_exec_pkg::ALU_SLT;
                    3'b011: op_d = rv_exec_pkg::ALU_SLTU;
                    3'b100: op_d = rv_exec_pkg::ALU_XOR;
                    3'b110: op_d = rv_exec_pkg::ALU_OR;
                    3'b111: op_d = rv_exec_pkg::ALU_AND;
                    3'b001:
                    begin
                        if (iw.r_fmt.funct7 == rv_exec_pkg::F7_BASE)
                            op_d = rv_exec_pkg::ALU_SLL;
                        else
                            illegal_d = 1'b1;
                    end
                    default:
                    begin
                        if (iw.r_fmt.funct7 == rv_exec_pkg::F7_BASE)
                            op_d = rv_exec_pkg::ALU_SRL;
                        else if (iw.r_fmt.funct7 == rv_exec_pkg::F7_ALT)
                            op_d = rv_exec_pkg::ALU_SRA;
                        else
                            illegal_d = 1'b1;
                    end
                endcase
            end
            rv_exec_pkg::OPC_LUI:
            begin
                op_d  = rv_exec_pkg::ALU_LUI;
                imm_d = u_imm;
            end
            rv_exec_pkg::OPC_AUIPC:
            begin
                op_d  = rv_exec_pkg::ALU_AUIPC;
                imm_d = u_imm;
            end
            rv_exec_pkg::OPC_JAL:
            begin
                op_d  = rv_exec_pkg::ALU_JAL;
                imm_d = j_imm;
            end
            rv_exec_pkg::OPC_JALR:
            begin
                imm_d = i_imm;
                if (iw.i_fmt.funct3 == 3'b000)
                    op_d = rv_exec_pkg::ALU_JALR;
                else
                    illegal_d = 1'b1;
            end
            rv_exec_pkg::OPC_BRANCH:
            begin
                imm_d = b_imm;
                case (iw.b_fmt.funct3)
                    3'b000:  op_d = rv_exec_pkg::ALU_BEQ;
                    3'b001:  op_d = rv_exec_pkg::ALU_BNE;
                    3'b100:  op_d = rv_exec_pkg::ALU_BLT;
                    3'b101:  op_d = rv_exec_pkg::ALU_BGE;
                    3'b110:  op_d = rv_exec_pkg::ALU_BLTU;
                    3'b111:  op_d = rv_exec_pkg::ALU_BGEU;
                    default: illegal_d = 1'b1;
                endcase
            end
            default: illegal_d = 1'b1;
        endcase
        if (illegal_d)
            op_d = rv_exec_pkg::ALU_NOP;
    end

    // Free slot, or the result stage drains this one now.
    assign in_ready = !dec_valid || dec_ready;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            dec_valid <= 1'b0;
        else if (in_ready)
            dec_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            dec_op      <= op_d;
            dec_a       <= rs1_data;
            dec_b       <= b_d;
            dec_pc      <= pc;
            dec_imm     <= imm_d;
            dec_illegal <= illegal_d;
        end
    end

    a_dec_hold: assert property (@(posedge clk) disable iff (!arst_n)
        dec_valid && !dec_ready |=> dec_valid &&
        $stable({dec_op, dec_a, dec_b, dec_pc, dec_imm, dec_illegal}))
        else $error("decode payload changed under back-pressure");

endmodule

// File: hw/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_exec_pkg::alu_op_e              dec_op,
    input  logic [rv_exec_pkg::XLEN-1:0]      dec_a,
    input  logic [rv_exec_pkg::XLEN-1:0]      dec_b,
    input  logic [rv_exec_pkg::XLEN-1:0]      dec_pc,
    input  logic [rv_exec_pkg::XLEN-1:0]      dec_imm,
    output logic [rv_exec_pkg::XLEN-1:0]      alu_result,
    output logic                              alu_taken,
    output logic [rv_exec_pkg::XLEN-1:0]      alu_target
);

    logic [4:0]                       shamt;
    logic                             eq;
    logic                             lt_s;
    logic                             lt_u;
    logic [rv_exec_pkg::XLEN-1:0]     pc_imm;
    logic [rv_exec_pkg::XLEN-1:0]     pc_link;
    logic [rv_exec_pkg::XLEN-1:0]     jalr_sum;

    assign shamt    = dec_b[4:0];  // Only the low five bits shift.
    assign eq       = (dec_a == dec_b);
    assign lt_s     = ($signed(dec_a) < $signed(dec_b));
    assign lt_u     = (dec_a < dec_b);
    assign pc_imm   = dec_pc + dec_imm;
    assign pc_link  = dec_pc + 32'd4;
    assign jalr_sum = dec_a + dec_imm;

    always_comb
    begin
        alu_result = '0;
        alu_taken  = 1'b0;
        alu_target = '0;
        case (dec_op)
            rv_exec_pkg::ALU_ADD:   alu_result = dec_a + dec_b;
            rv_exec_pkg::ALU_SUB:   alu_result = dec_a - dec_b;
            rv_exec_pkg::ALU_SLL:   alu_result = dec_a << shamt;
            rv_exec_pkg::ALU_SLT:   alu_result = {31'b0, lt_s};
            rv_exec_pkg::ALU_SLTU:  alu_result = {31'b0, lt_u};
            rv_exec_pkg::ALU_XOR:   alu_result = dec_a ^ dec_b;
            rv_exec_pkg::ALU_SRL:   alu_result = dec_a >> shamt;
            rv_exec_pkg::ALU_SRA:   alu_result = $unsigned($signed(dec_a) >>> shamt);
            rv_exec_pkg::ALU_OR:    alu_result = dec_a | dec_b;
            rv_exec_pkg::ALU_AND:   alu_result = dec_a & dec_b;
            rv_exec_pkg::ALU_LUI:   alu_result = dec_imm;
            rv_exec_pkg::ALU_AUIPC: alu_result = pc_imm;
            rv_exec_pkg::ALU_JAL:
            begin
                alu_result = pc_link;
                alu_taken  = 1'b1;
                alu_target = pc_imm;
            end
            rv_exec_pkg::ALU_JALR:
            begin
                alu_result = pc_link;
                alu_taken  = 1'b1;
                alu_target = {jalr_sum[rv_exec_pkg::XLEN-1:1], 1'b0};
            end
            rv_exec_pkg::ALU_BEQ:
            begin
                alu_taken  = eq;
                alu_target = pc_imm;
            end
            rv_exec_pkg::ALU_BNE:
            begin
                alu_taken  = !eq;
                alu_target = pc_imm;
            end
            rv_exec_pkg::ALU_BLT:
            begin
                alu_taken  = lt_s;
                alu_target = pc_imm;
            end
            rv_exec_pkg::ALU_BGE:
            begin
                alu_taken  = !lt_s;
                alu_target = pc_imm;
            end
            rv_exec_pkg::ALU_BLTU:
            begin
                alu_taken  = lt_u;
                alu_target = pc_imm;
            end
            rv_exec_pkg::ALU_BGEU:
            begin
                alu_taken  = !lt_u;
                alu_target = pc_imm;
            end
            default:
            begin
                // NOP and illegal words leave everything at zero.
                alu_result = '0;
            end
        endcase
    end

endmodule

// File: hw/rv_result_stage.sv
`timescale 1ns/1ps

module rv_result_stage (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              dec_valid,
    output logic                              dec_ready,
    input  logic [rv_exec_pkg::XLEN-1:0]      alu_result,
    input  logic                              alu_taken,
    input  logic [rv_exec_pkg::XLEN-1:0]      alu_target,
    input  logic                              dec_illegal,
    output logic                              out_valid,
    input  logic                              out_ready,
    output logic [rv_exec_pkg::XLEN-1:0]      result,
    output logic                              branch_taken,
    output logic [rv_exec_pkg::XLEN-1:0]      target,
    output logic                              illegal
);

    assign dec_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            out_valid <= 1'b0;
        else if (dec_ready)
            out_valid <= dec_valid;
    end

    // Loaded only on a transfer from decode.
    always_ff @(posedge clk)
    begin
        if (dec_valid && dec_ready)
        begin
            result       <= alu_result;
            branch_taken <= alu_taken;
            target       <= alu_target;
            illegal      <= dec_illegal;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid &&
        $stable({result, branch_taken, target, illegal}))
        else $error("output dropped or changed under back-pressure");

    // Illegal words decode to NOP, which never takes a branch.
    a_taken_legal: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> !(branch_taken && illegal))
        else $error("illegal instruction marked as taken");

endmodule

// File: hw/rv_exec_unit.sv
`timescale 1ns/1ps

module rv_exec_unit (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    output logic                              in_ready,
    input  logic [31:0]                       instr,
    input  logic [rv_exec_pkg::XLEN-1:0]      rs1_data,
    input  logic [rv_exec_pkg::XLEN-1:0]      rs2_data,
    input  logic [rv_exec_pkg::XLEN-1:0]      pc,
    output logic                              out_valid,
    input  logic                              out_ready,
    output logic [rv_exec_pkg::XLEN-1:0]      result,
    output logic                              branch_taken,
    output logic [rv_exec_pkg::XLEN-1:0]      target,
    output logic                              illegal
);

    logic                             dec_valid;
    logic                             dec_ready;
    rv_exec_pkg::alu_op_e             dec_op;
    logic [rv_exec_pkg::XLEN-1:0]     dec_a;
    logic [rv_exec_pkg::XLEN-1:0]     dec_b;
    logic [rv_exec_pkg::XLEN-1:0]     dec_pc;
    logic [rv_exec_pkg::XLEN-1:0]     dec_imm;
    logic                             dec_illegal;
    logic [rv_exec_pkg::XLEN-1:0]     alu_result;
    logic                             alu_taken;
    logic [rv_exec_pkg::XLEN-1:0]     alu_target;

    rv_decoder u_decoder (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .pc          (pc),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_op      (dec_op),
        .dec_a       (dec_a),
        .dec_b       (dec_b),
        .dec_pc      (dec_pc),
        .dec_imm     (dec_imm),
        .dec_illegal (dec_illegal)
    );

    rv_alu u_alu (
        .dec_op     (dec_op),
        .dec_a      (dec_a),
        .dec_b      (dec_b),
        .dec_pc     (dec_pc),
        .dec_imm    (dec_imm),
        .alu_result (alu_result),
        .alu_taken  (alu_taken),
        .alu_target (alu_target)
    );

    rv_result_stage u_result (
        .clk          (clk),
        .arst_n       (arst_n),
        .dec_valid    (dec_valid),
        .dec_ready    (dec_ready),
        .alu_result   (alu_result),
        .alu_taken    (alu_taken),
        .alu_target   (alu_target),
        .dec_illegal  (dec_illegal),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .result       (result),
        .branch_taken (branch_taken),
        .target       (target),
        .illegal      (illegal)
    );

endmodule

// File: verification/tb_rv_exec_unit.sv
`timescale 1ns/1ps

module tb_rv_exec_unit;

    localparam int CLK_PERIOD = 100;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] pc;
        logic [31:0] result;
        logic        taken;
        logic [31:0] target;
        logic        illegal;
    } entry_t;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] instr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] pc;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] result;
    logic        branch_taken;
    logic [31:0] target;
    logic        illegal;

    entry_t      cases[$];
    int          checked;
    logic        table_ready;
    logic        held;
    logic [31:0] held_result;
    logic        held_taken;
    logic [31:0] held_target;
    logic        held_illegal;

    rv_exec_unit UUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .instr        (instr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .pc           (pc),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .result       (result),
        .branch_taken (branch_taken),
        .target       (target),
        .illegal      (illegal)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3);
        rv_exec_pkg::rv_instr_u w;
        w.r_fmt.funct7 = f7;
        w.r_fmt.rs2    = 5'd2;
        w.r_fmt.rs1    = 5'd1;
        w.r_fmt.funct3 = f3;
        w.r_fmt.rd     = 5'd3;
        w.r_fmt.opcode = rv_exec_pkg::OPC_OP;
        return w;
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [6:0] opc);
        rv_exec_pkg::rv_instr_u w;
        w.i_fmt.imm_11_0 = imm;
        w.i_fmt.rs1      = 5'd1;
        w.i_fmt.funct3   = f3;
        w.i_fmt.rd       = 5'd4;
        w.i_fmt.opcode   = opc;
        return w;
    endfunction

    // Byte offset whose bit 0 is dropped.
    function automatic logic [31:0] b_word(input logic [12:0] off, input logic [2:0] f3);
        rv_exec_pkg::rv_instr_u w;
        w.b_fmt.imm_12   = off[12];
        w.b_fmt.imm_10_5 = off[10:5];
        w.b_fmt.rs2      = 5'd2;
        w.b_fmt.rs1      = 5'd1;
        w.b_fmt.funct3   = f3;
        w.b_fmt.imm_4_1  = off[4:1];
        w.b_fmt.imm_11   = off[11];
        w.b_fmt.opcode   = rv_exec_pkg::OPC_BRANCH;
        return w;
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [6:0] opc);
        rv_exec_pkg::rv_instr_u w;
        w.u_fmt.imm_31_12 = imm;
        w.u_fmt.rd        = 5'd5;
        w.u_fmt.opcode    = opc;
        return w;
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] off);
        rv_exec_pkg::rv_instr_u w;
        w.j_fmt.imm_20    = off[20];
        w.j_fmt.imm_10_1  = off[10:1];
        w.j_fmt.imm_11    = off[11];
        w.j_fmt.imm_19_12 = off[19:12];
        w.j_fmt.rd        = 5'd1;
        w.j_fmt.opcode    = rv_exec_pkg::OPC_JAL;
        return w;
    endfunction

    task automatic add_case(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] p, input logic [31:0] res, input logic tk,
                            input logic [31:0] tgt, input logic ill);
        entry_t e;
        e.instr   = ins;
        e.rs1     = a;
        e.rs2     = b;
        e.pc      = p;
        e.result  = res;
        e.taken   = tk;
        e.target  = tgt;
        e.illegal = ill;
        cases.push_back(e);
    endtask

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic build_table();
        // Register ops. Shift amounts come from rs2[4:0] only.
        add_case(r_word(7'h00, 3'b000), 32'h5, 32'hFFFF_FFFE, 32'h100, 32'h3, 0, 0, 0);
        add_case(r_word(7'h20, 3'b000), 32'h5, 32'h7, 32'h104, 32'hFFFF_FFFE, 0, 0, 0);
        add_case(r_word(7'h00, 3'b001), 32'h1, 32'h24, 32'h108, 32'h10, 0, 0, 0);
        add_case(r_word(7'h00, 3'b010), 32'hFFFF_FFFF, 32'h1, 32'h10C, 32'h1, 0, 0, 0);
        add_case(r_word(7'h00, 3'b011), 32'hFFFF_FFFF, 32'h1, 32'h110, 32'h0, 0, 0, 0);
        add_case(r_word(7'h00, 3'b100), 32'hF0F0_F0F0, 32'h0FF0_0FF0, 32'h114, 32'hFF00_FF00,
                 0, 0, 0);
        add_case(r_word(7'h00, 3'b101), 32'h8000_0000, 32'h21, 32'h118, 32'h4000_0000, 0, 0, 0);
        add_case(r_word(7'h20, 3'b101), 32'h8000_0000, 32'h3F, 32'h11C, 32'hFFFF_FFFF, 0, 0, 0);
        add_case(r_word(7'h00, 3'b110), 32'h1200_0034, 32'h0045_6700, 32'h120, 32'h1245_6734,
                 0, 0, 0);
        add_case(r_word(7'h00, 3'b111), 32'hFFFF_00FF, 32'h1234_5678, 32'h124, 32'h1234_0078,
                 0, 0, 0);
        // Immediate ops.
        add_case(i_word(12'hFFF, 3'b000, rv_exec_pkg::OPC_OP_IMM), 32'h10, 0, 32'h200,
                 32'hF, 0, 0, 0);
        add_case(i_word(12'h001, 3'b010, rv_exec_pkg::OPC_OP_IMM), 32'hFFFF_FFFF, 0, 32'h204,
                 32'h1, 0, 0, 0);
        add_case(i_word(12'h001, 3'b011, rv_exec_pkg::OPC_OP_IMM), 32'hFFFF_FFFF, 0, 32'h208,
                 32'h0, 0, 0, 0);
        add_case(i_word(12'h800, 3'b100, rv_exec_pkg::OPC_OP_IMM), 32'hFF, 0, 32'h20C,
                 32'hFFFF_F8FF, 0, 0, 0);
        add_case(i_word(12'h0F0, 3'b110, rv_exec_pkg::OPC_OP_IMM), 32'hF00, 0, 32'h210,
                 32'hFF0, 0, 0, 0);
        add_case(i_word(12'h7FF, 3'b111, rv_exec_pkg::OPC_OP_IMM), 32'hABCD_EF12, 0, 32'h214,
                 32'h712, 0, 0, 0);
        add_case(i_word(12'h008, 3'b001, rv_exec_pkg::OPC_OP_IMM), 32'hAB, 0, 32'h218,
                 32'hAB00, 0, 0, 0);
        add_case(i_word(12'h004, 3'b101, rv_exec_pkg::OPC_OP_IMM), 32'hF000_0000, 0, 32'h21C,
                 32'h0F00_0000, 0, 0, 0);
        add_case(i_word(12'h404, 3'b101, rv_exec_pkg::OPC_OP_IMM), 32'hF000_0000, 0, 32'h220,
                 32'hFF00_0000, 0, 0, 0);
        // Upper immediates. AUIPC wraps around.
        add_case(u_word(20'h12345, rv_exec_pkg::OPC_LUI), 0, 0, 32'h300, 32'h1234_5000, 0, 0, 0);
        add_case(u_word(20'hFFFFF, rv_exec_pkg::OPC_AUIPC), 0, 0, 32'h2000, 32'h1000, 0, 0, 0);
        // Jumps link pc+4.
        add_case(j_word(21'h000100), 0, 0, 32'h1000, 32'h1004, 1, 32'h1100, 0);
        add_case(j_word(21'h1FFFF8), 0, 0, 32'h2000, 32'h2004, 1, 32'h1FF8, 0);
        add_case(i_word(12'h005, 3'b000, rv_exec_pkg::OPC_JALR), 32'h3000, 0, 32'h400,
                 32'h404, 1, 32'h3004, 0);
        // Operands -1 against 1 split signed from unsigned branches.
        add_case(b_word(13'h0010, 3'b000), 32'h55, 32'h55, 32'h800, 0, 1, 32'h810, 0);
        add_case(b_word(13'h0010, 3'b000), 32'h55, 32'h56, 32'h800, 0, 0, 32'h810, 0);
        add_case(b_word(13'h1FE0, 3'b001), 32'h55, 32'h56, 32'h800, 0, 1, 32'h7E0, 0);
        add_case(b_word(13'h0010, 3'b100), 32'hFFFF_FFFF, 32'h1, 32'h800, 0, 1, 32'h810, 0);
        add_case(b_word(13'h0010, 3'b101), 32'hFFFF_FFFF, 32'h1, 32'h800, 0, 0, 32'h810, 0);
        add_case(b_word(13'h0010, 3'b110), 32'hFFFF_FFFF, 32'h1, 32'h800, 0, 0, 32'h810, 0);
        add_case(b_word(13'h0010, 3'b111), 32'hFFFF_FFFF, 32'h1, 32'h800, 0, 1, 32'h810, 0);
        add_case(b_word(13'h1FE0, 3'b101), 32'h7, 32'h7, 32'h800, 0, 1, 32'h7E0, 0);
        // LW opcode and then a MUL word.
        add_case(i_word(12'h004, 3'b010, 7'b0000011), 32'h1234, 0, 32'h900, 0, 0, 0, 1);
        add_case(r_word(7'h01, 3'b000), 32'h3, 32'h4, 32'h904, 0, 0, 0, 1);
    endtask

    initial
    begin
        void'($urandom(32'h3bacf3ed));
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        instr       = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        pc          = '0;
        out_ready   = 1'b0;
        checked     = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        assert (in_ready && !out_valid)
        else
        begin
            $display("Wrong state after reset: in_ready is low or out_valid is high");
            abort_run();
        end
        for (int i = 0; i < cases.size(); i++)
        begin
            @(negedge clk);
            in_valid = 1'b1;
            instr    = cases[i].instr;
            rs1_data = cases[i].rs1;
            rs2_data = cases[i].rs2;
            pc       = cases[i].pc;
            @(posedge clk);
            while (!in_ready)
                @(posedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
        wait (checked == cases.size());
        repeat (4) @(posedge clk);  // Room for a stray extra output.
        $display("Everything OK");
        $finish;
    end

    // Consumer is ready three cycles in four on average.
    initial
    begin
        forever
        begin
            @(negedge clk);
            out_ready = ($urandom() % 4) != 0;
        end
    end

    initial
    begin
        held = 1'b0;
        forever
        begin
            @(posedge clk);
            if (arst_n)
            begin
                if (held)
                begin
                    assert (out_valid)
                    else
                    begin
                        $display("out_valid dropped before out_ready was seen");
                        abort_run();
                    end
                    compare_word("result", result, held_result);
                    compare_word("branch_taken", {31'b0, branch_taken}, {31'b0, held_taken});
                    compare_word("target", target, held_target);
                    compare_word("illegal", {31'b0, illegal}, {31'b0, held_illegal});
                end
                if (out_valid && out_ready)
                begin
                    assert (checked < cases.size())
                    else
                    begin
                        $display("Output transfer with no table entry left to match");
                        abort_run();
                    end
                    compare_word("result", result, cases[checked].result);
                    compare_word("branch_taken", {31'b0, branch_taken},
                                 {31'b0, cases[checked].taken});
                    compare_word("target", target, cases[checked].target);
                    compare_word("illegal", {31'b0, illegal}, {31'b0, cases[checked].illegal});
                    checked++;
                end
                held         = out_valid && !out_ready;
                held_result  = result;
                held_taken   = branch_taken;
                held_target  = target;
                held_illegal = illegal;
            end
        end
    end

    // Twenty cycles per entry is far beyond the worst stall run.
    initial
    begin
        wait (table_ready);
        repeat (cases.size() * 20 + 4) @(posedge clk);
        $display("Timeout: not all table entries came out in time");
        abort_run();
    end

endmodule

// File: project.f
hw/rv_exec_pkg.sv
hw/rv_decoder.sv
hw/rv_alu.sv
hw/rv_result_stage.sv
hw/rv_exec_unit.sv
verification/tb_rv_exec_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute-path testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_exec_unit \
    -f project.f -o sim_tb \
    || { echo "Build failed"; exit 1; }

# The simulation output goes to the terminal and is searched for the pass line.
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Everything OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
